// ==== list.f ====
+incdir+tests
logic/video_pkg.sv
logic/display_if.sv
logic/display_timing.sv
logic/sprite_engine.sv
logic/pixel_painter.sv
logic/tmds_encoder.sv
logic/sprite_display_top.sv
tests/tb_sprite_display.sv

// ==== Makefile ====
# Verilator flow for the sprite display testbench

TOP = tb_sprite_display
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f list.f --top-module sprite_display_top

obj_dir/V$(TOP): list.f logic/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	cp logic/letter_f.mem letter_f.mem
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG) letter_f.mem

// ==== logic/letter_f.mem ====
// One sprite row per line, 8 pixels in binary, leftmost pixel first
01111110
01100000
01100000
01111100
01100000
01100000
01100000
00000000

// ==== tests/tb_video_model.svh ====
/* Reference model of the video pipeline, included in the testbench module.
   Tracks the DUT coordinate from reset; the 3-cycle delay is kept by the caller. */

`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

logic [7:0] rom_m [video_pkg::SPR_H];  // Sprite bitmap, MSB is the left pixel
int         mx;                        // Coordinate the DUT holds right now
int         my;
int         pos_x;                     // Sprite position of the current frame
int         pos_y;
bit         first_frame;               // Line 0 of this frame has no sprite
int         disp_m [3];                // Running disparity per channel

// Galois LFSR, 16 bit, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Raster step, same wrap as the timing generator
function automatic void advance_coord();
    if (mx == video_pkg::H_TOTAL - 1) begin
        mx = 0;
        my = (my == video_pkg::V_TOTAL - 1) ? 0 : my + 1;
    end else begin
        mx = mx + 1;
    end
endfunction

function automatic bit active_at(input int x, input int y);
    return (x < video_pkg::H_RES) && (y < video_pkg::V_RES);
endfunction

function automatic bit hsync_at(input int x);
    return (x >= video_pkg::H_RES + video_pkg::H_FP) &&
           (x < video_pkg::H_RES + video_pkg::H_FP + video_pkg::H_SYNC);
endfunction

function automatic bit vsync_at(input int y);
    return (y >= video_pkg::V_RES + video_pkg::V_FP) &&
           (y < video_pkg::V_RES + video_pkg::V_FP + video_pkg::V_SYNC);
endfunction

// Set sprite pixel at (x,y), box is 16x16 from the frame's position
function automatic bit sprite_on(input int x, input int y);
    int span;
    int col;
    int row;
    span = video_pkg::SPR_W * video_pkg::SPR_SCALE;
    if (first_frame && (y == 0)) return 1'b0;
    if ((x < pos_x) || (x >= pos_x + span)) return 1'b0;
    if ((y < pos_y) || (y >= pos_y + span)) return 1'b0;
    col = (x - pos_x) / video_pkg::SPR_SCALE;
    row = (y - pos_y) / video_pkg::SPR_SCALE;
    return rom_m[row][video_pkg::SPR_W - 1 - col];
endfunction

function automatic logic [9:0] control_symbol(input logic [1:0] c);
    case (c)
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

// DVI 8b/10b data symbol, cnt is the running disparity
function automatic logic [9:0] tmds_encode(input logic [7:0] d, inout int cnt);
    int         n1d;
    int         n1q;
    int         n0q;
    bit         use_xnor;
    logic [8:0] qm;
    logic [9:0] word;
    n1d      = $countones(d);
    use_xnor = (n1d > 4) || ((n1d == 4) && (d[0] == 1'b0));
    qm[0]    = d[0];
    for (int i = 1; i < 8; i++) begin
        qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
    end
    qm[8] = !use_xnor;
    n1q   = $countones(qm[7:0]);
    n0q   = 8 - n1q;
    if ((cnt == 0) || (n1q == n0q)) begin
        word = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
        cnt  = qm[8] ? cnt + n1q - n0q : cnt + n0q - n1q;
    end else if (((cnt > 0) && (n1q > n0q)) || ((cnt < 0) && (n0q > n1q))) begin
        word = {1'b1, qm[8], ~qm[7:0]};
        cnt  = cnt + (qm[8] ? 2 : 0) + n0q - n1q;
    end else begin
        word = {1'b0, qm[8], qm[7:0]};
        cnt  = cnt - (qm[8] ? 0 : 2) + n1q - n0q;
    end
    return word;
endfunction

`endif

// ==== tests/tb_sprite_display.sv ====
/* Runs five frames after reset: background, fixed sprite, three random positions.
   Every TMDS word is predicted by the included model, 3 cycles behind the coordinate.
   Sprite file is read from the project root as logic/letter_f.mem. */

`timescale 1ns/1ps

module tb_sprite_display;

    localparam int NUM_FRAMES   = 5;
    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int RUN_LIMIT_NS = (NUM_FRAMES + 1) * FRAME_CYCLES * 10 + 2000;

    logic       clk_pix;
    logic       arst_n;
    logic [7:0] sprx;
    logic [7:0] spry;
    wire  [9:0] tmds_ch0;
    wire  [9:0] tmds_ch1;
    wire  [9:0] tmds_ch2;

    `include "tb_video_model.svh"

    int          errors;
    int          checks;
    int          frame_idx;
    logic [15:0] lfsr_state;
    logic [7:0]  next_x;       // Position driven at the next stimulus slot
    logic [7:0]  next_y;
    string       phase;
    logic [9:0]  exp_ch0 [$];  // Words on their way through the 3 stage delay
    logic [9:0]  exp_ch1 [$];
    logic [9:0]  exp_ch2 [$];
    string       exp_name [$];

    sprite_display_top DUT (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .sprx     (sprx),
        .spry     (spry),
        .tmds_ch0 (tmds_ch0),
        .tmds_ch1 (tmds_ch1),
        .tmds_ch2 (tmds_ch2)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Takes n bits, one LFSR step each
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic void queue_expected(input logic [9:0] c0, input logic [9:0] c1,
                                           input logic [9:0] c2, input string name);
        exp_ch0.push_back(c0);
        exp_ch1.push_back(c1);
        exp_ch2.push_back(c2);
        exp_name.push_back(name);
    endfunction

    // Position for the frame after frame f
    task automatic pick_position(input int f);
        case (f)
            0: begin
                next_x = 8'd10;
                next_y = 8'd8;
            end
            2: begin
                next_x = 8'd56 + random_bits(3);  // Right and bottom edges, clipped
                next_y = 8'd40 + random_bits(3);
            end
            default: begin
                next_x = random_bits(6);
                next_y = random_bits(6);
            end
        endcase
    endtask

    // One cycle of the model, then compare with the word 3 cycles old
    task automatic model_cycle();
        bit         on;
        logic [9:0] c0;
        logic [9:0] c1;
        logic [9:0] c2;
        if ((mx == 0) && (my == 0)) begin
            frame_idx++;
            first_frame = (frame_idx == 0);
            pos_x = sprx;  // Port value the DUT latches at this coordinate
            pos_y = spry;
            phase = (frame_idx == 0) ? "background" :
                    (frame_idx == 1) ? "sprite_shape" : "random";
        end
        if (!active_at(mx, my)) begin
            c0 = control_symbol({vsync_at(my), hsync_at(mx)});
            c1 = control_symbol(2'b00);
            c2 = control_symbol(2'b00);
            disp_m[0] = 0;
            disp_m[1] = 0;
            disp_m[2] = 0;
            queue_expected(c0, c1, c2, "sync");
        end else begin
            on = sprite_on(mx, my);
            c0 = tmds_encode(on ? {2{video_pkg::COL_SPR_B}} : {2{video_pkg::COL_BG_B}},
                             disp_m[0]);
            c1 = tmds_encode(on ? {2{video_pkg::COL_SPR_G}} : {2{video_pkg::COL_BG_G}},
                             disp_m[1]);
            c2 = tmds_encode(on ? {2{video_pkg::COL_SPR_R}} : {2{video_pkg::COL_BG_R}},
                             disp_m[2]);
            queue_expected(c0, c1, c2, phase);
        end
        check_value({exp_name[0], " ch0"}, 32'(exp_ch0.pop_front()), 32'(tmds_ch0));
        check_value({exp_name[0], " ch1"}, 32'(exp_ch1.pop_front()), 32'(tmds_ch1));
        check_value({exp_name[0], " ch2"}, 32'(exp_ch2.pop_front()), 32'(tmds_ch2));
        void'(exp_name.pop_front());
        if ((my == video_pkg::V_RES / 2) && (mx == 0)) begin
            pick_position(frame_idx);  // Mid frame, applies from the next one
        end
        advance_coord();
    endtask

    initial begin
        $readmemb("logic/letter_f.mem", rom_m);
        errors     = 0;
        checks     = 0;
        frame_idx  = -1;
        lfsr_state = 16'd47;
        mx         = 0;
        my         = 0;
        disp_m[0]  = 0;
        disp_m[1]  = 0;
        disp_m[2]  = 0;
        next_x     = 8'd70;  // Off screen for the background frame
        next_y     = 8'd0;
        sprx       = next_x;
        spry       = next_y;
        arst_n     = 1'b0;
        // Reset held 8 cycles, outputs idle the whole time
        repeat (8) begin
            @(negedge clk_pix);
            check_value("idle ch0", 32'(control_symbol(2'b00)), 32'(tmds_ch0));
            check_value("idle ch1", 32'(control_symbol(2'b00)), 32'(tmds_ch1));
            check_value("idle ch2", 32'(control_symbol(2'b00)), 32'(tmds_ch2));
            check_value("idle drawing", 32'd0, 32'(DUT.u_sprite.drawing));
        end
        @(posedge clk_pix);
        #1 arst_n = 1'b1;
        // Pipeline still shows reset words for 3 cycles
        repeat (3) queue_expected(control_symbol(2'b00), control_symbol(2'b00),
                                  control_symbol(2'b00), "idle");
        repeat (NUM_FRAMES * FRAME_CYCLES + 3) begin
            @(negedge clk_pix);
            model_cycle();
            @(posedge clk_pix);
            #1;
            sprx = next_x;
            spry = next_y;
        end
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, a little over the planned frames
    initial begin
        #(RUN_LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", RUN_LIMIT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== logic/sprite_display_top.sv ====
/* Parallel 10-bit TMDS words out; serializer and pin buffers not included.
   Fixed latency, a coordinate reaches the TMDS ports 3 cycles later.
   sprx/spry take effect from the next frame. */

`timescale 1ns/1ps

module sprite_display_top (
    input  logic                         clk_pix,
    input  logic                         arst_n,
    input  logic [video_pkg::CORDW-1:0]  sprx,
    input  logic [video_pkg::CORDW-1:0]  spry,
    output logic [9:0]                   tmds_ch0,  // Blue plus sync
    output logic [9:0]                   tmds_ch1,  // Green
    output logic [9:0]                   tmds_ch2   // Red
);

    logic       pix;
    logic       drawing;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hs;
    logic       vs;
    logic       de_out;

    display_if disp ();

    display_timing u_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp.source)
    );

    sprite_engine u_sprite (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp.sink),
        .sprx    (sprx),
        .spry    (spry),
        .pix     (pix),
        .drawing (drawing)
    );

    pixel_painter u_painter (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp.sink),
        .pix     (pix),
        .drawing (drawing),
        .r       (r),
        .g       (g),
        .b       (b),
        .hs      (hs),
        .vs      (vs),
        .de_out  (de_out)
    );

    // Sync rides on channel 0 only
    tmds_encoder u_enc_ch0 (
        .clk_pix (clk_pix), .arst_n (arst_n),
        .data (b), .ctrl ({vs, hs}), .de (de_out), .tmds (tmds_ch0)
    );

    tmds_encoder u_enc_ch1 (
        .clk_pix (clk_pix), .arst_n (arst_n),
        .data (g), .ctrl (2'b00), .de (de_out), .tmds (tmds_ch1)
    );

    tmds_encoder u_enc_ch2 (
        .clk_pix (clk_pix), .arst_n (arst_n),
        .data (r), .ctrl (2'b00), .de (de_out), .tmds (tmds_ch2)
    );

endmodule

// ==== logic/tmds_encoder.sv ====
/* DVI 1.0 TMDS encoder for one channel with registered output.
   Blanking sends the control symbol for ctrl and clears the disparity. */

`timescale 1ns/1ps

module tmds_encoder (
    input  logic       clk_pix,
    input  logic       arst_n,
    input  logic [7:0] data,
    input  logic [1:0] ctrl,
    input  logic       de,
    output logic [9:0] tmds
);

    logic [3:0]        n1_d;      // Ones in input byte
    logic              use_xnor;
    logic [8:0]        q_m;       // Transition minimized word with XOR flag in bit 8
    logic [3:0]        n1_qm;
    logic signed [5:0] balance;   // Ones minus zeros of q_m[7:0]
    logic signed [5:0] disp_cnt;  // Running disparity

    // Stage 1 picks XOR or XNOR for fewer transitions
    always_comb begin
        n1_d     = 4'($countones(data));
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8]  = ~use_xnor;
        n1_qm   = 4'($countones(q_m[7:0]));
        balance = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;  // 2*n1 - 8
    end

    // Stage 2 balances DC
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            tmds     <= 10'b1101010100;  // Blank with sync low
            disp_cnt <= '0;
        end else if (!de) begin
            disp_cnt <= '0;
            case (ctrl)
                2'b00:   tmds <= 10'b1101010100;
                2'b01:   tmds <= 10'b0010101011;
                2'b10:   tmds <= 10'b0101010100;
                default: tmds <= 10'b1010101011;
            endcase
        end else if ((disp_cnt == 0) || (balance == 0)) begin
            // Neutral word where bit 9 tells the receiver about inversion
            tmds     <= {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_cnt <= q_m[8] ? disp_cnt + balance : disp_cnt - balance;
        end else if (((disp_cnt > 0) && (balance > 0)) ||
                     ((disp_cnt < 0) && (balance < 0))) begin
            tmds     <= {1'b1, q_m[8], ~q_m[7:0]};  // Invert to pull disparity back
            disp_cnt <= disp_cnt + (q_m[8] ? 6'sd2 : 6'sd0) - balance;
        end else begin
            tmds     <= {1'b0, q_m[8], q_m[7:0]};
            disp_cnt <= disp_cnt - (q_m[8] ? 6'sd0 : 6'sd2) + balance;
        end
    end

    // Data words are transition minimized so none can pass for a control symbol
    a_data_not_ctrl: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        de |=> !(tmds inside {10'b1101010100, 10'b0010101011,
                              10'b0101010100, 10'b1010101011})
    );

endmodule

// ==== logic/pixel_painter.sv ====
/* Colour is registered one cycle after the sprite output.
   Sync and de get two stages so all outputs line up. */

`timescale 1ns/1ps

module pixel_painter (
    input  logic       clk_pix,
    input  logic       arst_n,
    display_if.sink    disp,
    input  logic       pix,
    input  logic       drawing,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output logic       hs,
    output logic       vs,
    output logic       de_out
);
    import video_pkg::*;

    logic [3:0] paint_r;
    logic [3:0] paint_g;
    logic [3:0] paint_b;
    logic       hs_d;
    logic       vs_d;
    logic       de_d;

    // Sprite colour where a set bit is drawn, else background
    always_comb begin
        paint_r = (drawing && pix) ? COL_SPR_R : COL_BG_R;
        paint_g = (drawing && pix) ? COL_SPR_G : COL_BG_G;
        paint_b = (drawing && pix) ? COL_SPR_B : COL_BG_B;
    end

    // Sync and de, first stage matches the sprite engine
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hs_d   <= 1'b0;
            vs_d   <= 1'b0;
            de_d   <= 1'b0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            de_out <= 1'b0;
        end else begin
            hs_d   <= disp.hsync;
            vs_d   <= disp.vsync;
            de_d   <= disp.de;
            hs     <= hs_d;
            vs     <= vs_d;
            de_out <= de_d;
        end
    end

    // Nibble repeated, so F maps to FF and 0 to 00
    always_ff @(posedge clk_pix) begin
        r <= {2{paint_r}};
        g <= {2{paint_g}};
        b <= {2{paint_b}};
    end

endmodule

// ==== logic/sprite_engine.sv ====
/* sprx/spry sampled at frame; they must also be stable over the last line
   of the frame, where line 0 is fetched. Drawing clips at the active edge.
   Line 0 of the first frame after reset shows no sprite. */

`timescale 1ns/1ps

module sprite_engine (
    input  logic                         clk_pix,
    input  logic                         arst_n,
    display_if.sink                      disp,
    input  logic [video_pkg::CORDW-1:0]  sprx,
    input  logic [video_pkg::CORDW-1:0]  spry,
    output logic                         pix,
    output logic                         drawing
);
    import video_pkg::*;

    logic [SPR_W-1:0]                    rom [SPR_H];
    logic [SPR_W-1:0]                    row_r;      // Bitmap row for current line
    logic [CORDW-1:0]                    sprx_r;
    logic [CORDW-1:0]                    spry_r;
    logic [CORDW-1:0]                    pos_x;
    logic                                last_line;
    logic [CORDW-1:0]                    next_y;
    logic [CORDW-1:0]                    fetch_y;
    logic [CORDW:0]                      dy;         // Extra bit, set when line above sprite
    logic                                hit;
    logic                                hit_r;
    logic [CORDW-1:0]                    line_y_r;   // Line the row was fetched for
    logic [$clog2(SPR_H)-1:0]            row_idx_r;
    logic [$clog2(SPR_W*SPR_SCALE)-1:0]  cnt;        // Screen pixel within sprite
    logic [$clog2(SPR_W)-1:0]            col;
    sprite_state_t                       state;

    initial begin
        $readmemb(SPR_FILE, rom);
    end

    // Position latched once per frame
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sprx_r <= '0;
            spry_r <= '0;
        end else if (disp.frame) begin
            sprx_r <= sprx;
            spry_r <= spry;
        end
    end

    // At (0,0) the latch has not taken effect yet, so use the port
    assign pos_x = disp.frame ? sprx : sprx_r;

    // Which line comes next, and does it cross the sprite
    assign last_line = (disp.sy == CORDW'(V_TOTAL - 1));
    assign next_y    = last_line ? '0 : disp.sy + 1'b1;
    assign fetch_y   = last_line ? spry : spry_r;   // Next frame's position for line 0
    assign dy        = {1'b0, next_y} - {1'b0, fetch_y};
    assign hit       = !dy[CORDW] && (dy < (CORDW+1)'(SPR_H * SPR_SCALE));

    always_ff @(posedge clk_pix) begin
        if (disp.line) begin
            line_y_r  <= next_y;
            hit_r     <= hit;
            row_idx_r <= $clog2(SPR_H)'(dy / SPR_SCALE);  // Vertical scaling
        end
        if (state == FETCH) begin
            row_r <= rom[row_idx_r];
        end
    end

    // Row FSM, line pulse restarts it from any state
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (disp.line) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH: begin
                    state <= hit_r ? WAIT_POS : DONE;
                end
                WAIT_POS: begin
                    // Left edge on the target line, visible pixels only
                    if (disp.de && (disp.sy == line_y_r) && (disp.sx == pos_x)) begin
                        state <= DRAW;
                        cnt   <= '0;
                    end
                end
                DRAW: begin
                    if (cnt == ($clog2(SPR_W*SPR_SCALE))'(SPR_W * SPR_SCALE - 1)) begin
                        state <= DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: ;  // IDLE and DONE idle until the next line
            endcase
        end
    end

    // State shows the previous coordinate, so outputs lag it by one cycle
    assign col     = $clog2(SPR_W)'(cnt / SPR_SCALE);  // Horizontal scaling
    assign pix     = row_r[$clog2(SPR_W)'(SPR_W - 1) - col];  // Left pixel is MSB
    assign drawing = (state == DRAW);

    // Sprite output only ever follows an active coordinate
    a_draw_active: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        drawing |-> $past(disp.de)
    );

    // A run of sprite pixels never exceeds the scaled width
    a_draw_width: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        drawing [*SPR_W*SPR_SCALE] |=> !drawing
    );

endmodule

// ==== logic/display_timing.sv ====
/* Free running counters, reset to (0,0). Sync, de, line and frame
   are decoded straight from the counters, same cycle as sx and sy. */

`timescale 1ns/1ps

module display_timing (
    input  logic      clk_pix,
    input  logic      arst_n,
    display_if.source disp
);
    import video_pkg::*;

    logic [CORDW-1:0] sx;
    logic [CORDW-1:0] sy;
    logic             end_of_line;
    logic             end_of_frame;

    assign end_of_line  = (sx == CORDW'(H_TOTAL - 1));
    assign end_of_frame = (sy == CORDW'(V_TOTAL - 1));

    // Raster counters
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (end_of_line) begin
            sx <= '0;
            sy <= end_of_frame ? '0 : sy + 1'b1;  // Next line, or wrap to top
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // Decode
    always_comb begin
        disp.sx    = sx;
        disp.sy    = sy;
        disp.de    = (sx < CORDW'(H_RES)) && (sy < CORDW'(V_RES));
        // Sync pulses sit after the front porch, positive polarity
        disp.hsync = (sx >= CORDW'(H_RES + H_FP)) && (sx < CORDW'(H_RES + H_FP + H_SYNC));
        disp.vsync = (sy >= CORDW'(V_RES + V_FP)) && (sy < CORDW'(V_RES + V_FP + V_SYNC));
        disp.line  = (sx == CORDW'(H_RES));  // First blank pixel of every line
        disp.frame = (sx == '0) && (sy == '0);
    end

    // de may only come up at the left edge of a visible line
    a_de_rise: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        $rose(disp.de) |-> (sx == '0) && (sy < CORDW'(V_RES))
    );

    // Every hsync pulse is exactly H_SYNC pixels wide
    a_hsync_width: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        $rose(disp.hsync) |-> disp.hsync [*H_SYNC] ##1 !disp.hsync
    );

endmodule

// ==== logic/display_if.sv ====
/* Coordinates and sync of one pixel, all valid in the same cycle.
   No handshake, a new pixel every clock. */

`timescale 1ns/1ps

interface display_if;
    import video_pkg::*;

    logic [CORDW-1:0] sx;     // Horizontal position, blanking included
    logic [CORDW-1:0] sy;     // Vertical position
    logic             hsync;
    logic             vsync;
    logic             de;     // Active area
    logic             line;   // One cycle at the start of hblank
    logic             frame;  // One cycle at (0,0)

    // Timing generator side
    modport source (
        output sx, sy,
        output hsync, vsync, de,
        output line, frame
    );

    // Consumers only look
    modport sink (
        input sx, sy,
        input hsync, vsync, de,
        input line, frame
    );

endinterface

// ==== logic/video_pkg.sv ====
/* Small test mode of 64x48 active pixels, sync polarity positive.
   Sprite is 8x8 source pixels, each drawn as a 2x2 block on screen. */

package video_pkg;

    // Coordinate width, wide enough for both totals
    localparam int CORDW = 8;

    // Horizontal timing in pixels
    localparam int H_RES   = 64;
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BP    = 4;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 80

    // Vertical timing in lines
    localparam int V_RES   = 48;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 2;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 54

    // Sprite bitmap and scale
    localparam int SPR_W     = 8;
    localparam int SPR_H     = 8;
    localparam int SPR_SCALE = 2;
    localparam     SPR_FILE  = "letter_f.mem";  // binary rows, left pixel in MSB

    // Sprite colour, 4 bits per channel
    localparam logic [3:0] COL_SPR_R = 4'hF;
    localparam logic [3:0] COL_SPR_G = 4'hC;
    localparam logic [3:0] COL_SPR_B = 4'h0;

    // Background colour
    localparam logic [3:0] COL_BG_R = 4'h1;
    localparam logic [3:0] COL_BG_G = 4'h3;
    localparam logic [3:0] COL_BG_B = 4'h7;

    // Sprite row fetch FSM
    typedef enum logic [2:0] {
        IDLE,      // Out of reset, nothing fetched yet
        FETCH,     // Read ROM row for the coming line
        WAIT_POS,  // Row ready, wait for sprite x
        DRAW,      // Sprite pixels going out
        DONE       // Line finished or no sprite on it
    } sprite_state_t;

endpackage
